/* project.f */
playground_pkg.sv
reset_stretch.sv
bus_decode.sv
word_ram.sv
io_regs.sv
interval_timer.sv
led_sdm.sv
playground_top.sv
playground_props.sv
playground_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       := playground_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Testbench passed
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* playground_tb.sv */
// ##########################################################
// Directed tests for the peripheral bus slave
// RAM_WORDS and stretch width must match the DUT parameters
// ##########################################################
`timescale 1ns/1ps

module playground_tb;

   import playground_pkg::*;

   localparam int CLK_PERIOD         = 8;
   localparam int RESET_CYCLES       = 16;
   localparam int RAM_WORDS          = 256;
   localparam int RESET_STRETCH_BITS = 4;
   localparam int STRETCH            = 2 ** RESET_STRETCH_BITS;
   localparam int MAX_K              = 20; // Longest timer lead-in
   localparam int MAX_PERIOD         = 20; // Longest timer period
   localparam int ACCESS_CYCLES      = 3;  // Upper bound per bus access

   // Cycle budget per test
   // Watchdog allows twice the sum
   localparam int RESET_TEST  = RESET_CYCLES + 64 + 2 * ACCESS_CYCLES;
   localparam int RAM_TEST    = 26 * ACCESS_CYCLES;
   localparam int GPIO_TEST   = 8 * (2 * ACCESS_CYCLES + 1);
   localparam int INPUT_TEST  = 4 * (ACCESS_CYCLES + 3);
   localparam int TIMER_TEST  = 3 * ACCESS_CYCLES + MAX_K + 3 + 2 * MAX_PERIOD;
   localparam int LED_TEST    = 4 * ACCESS_CYCLES + 64 + 1024;
   localparam int WATCHDOG_NS = 2 * CLK_PERIOD *
      (RESET_TEST + RAM_TEST + GPIO_TEST + INPUT_TEST + TIMER_TEST + LED_TEST);

   logic       clk;
   logic       reset_button;
   word_t      mem_address;
   word_t      mem_wdata;
   byte_mask_t mem_wmask;
   logic       mem_rstrb;
   word_t      mem_rdata;
   logic       core_reset;
   logic       interrupt;
   gpio_t      gpio_in;
   gpio_t      gpio_out;
   gpio_t      gpio_dir;
   logic       led_red;
   logic       led_green;
   logic       led_blue;

   int checks      = 0;
   int errors      = 0;
   int cycle_count = 0; // Rising edges seen so far

   playground_top #(
      .RAM_WORDS          (RAM_WORDS),
      .RESET_STRETCH_BITS (RESET_STRETCH_BITS)
   ) dut_i (
      .clk          (clk),
      .reset_button (reset_button),
      .mem_address  (mem_address),
      .mem_wdata    (mem_wdata),
      .mem_wmask    (mem_wmask),
      .mem_rstrb    (mem_rstrb),
      .mem_rdata    (mem_rdata),
      .core_reset   (core_reset),
      .interrupt    (interrupt),
      .gpio_in      (gpio_in),
      .gpio_out     (gpio_out),
      .gpio_dir     (gpio_dir),
      .led_red      (led_red),
      .led_green    (led_green),
      .led_blue     (led_blue)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk)
      cycle_count <= cycle_count + 1;

   // One-hot IO address with the modifier in bits 3..2
   function automatic word_t io_address(input int bit_idx, input io_op_t op);
      return 32'h4000_0000 | (32'd1 << bit_idx) | (word_t'(op) << 2);
   endfunction

   // Keep old bytes where the mask bit is clear
   function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                         input byte_mask_t mask);
      word_t lanes;
      lanes = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
      return (old_w & ~lanes) | (new_w & lanes);
   endfunction

   task automatic check_value(input string name, input word_t got, input word_t exp);
      checks++;
      assert (got === exp)
      else
      begin
         errors++;
         $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic expect_true(input bit cond, input string what);
      checks++;
      assert (cond)
      else
      begin
         errors++;
         $display("%s", what);
      end
   endtask

   // Write lands on the second edge
   task automatic bus_write(input word_t addr, input word_t data, input byte_mask_t mask);
      @(posedge clk);
      mem_address <= addr;
      mem_wdata   <= data;
      mem_wmask   <= mask;
      @(posedge clk);
      mem_wmask   <= '0;
   endtask

   // One strobe cycle then data sampled with the address held
   task automatic bus_read(input word_t addr, output word_t data);
      @(posedge clk);
      mem_address <= addr;
      mem_rstrb   <= 1'b1;
      @(posedge clk);
      mem_rstrb   <= 1'b0;
      @(negedge clk);
      data = mem_rdata;
   endtask

   task automatic test_reset();
      word_t rd;
      int    release_cycle;
      int    k;
      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      expect_true(core_reset === 1'b1, "core_reset is low while reset_button is held");
      @(posedge clk);
      reset_button  <= 1'b0; // 16th edge still sees it high
      release_cycle = cycle_count;
      bus_read(io_address(IO_BIT_TICKS, IO_OP_WRITE), rd);
      check_value("ticks readback", rd, '0);
      bus_read(io_address(IO_BIT_RELOAD, IO_OP_WRITE), rd);
      check_value("reload readback", rd, '0);
      check_value("gpio_out", word_t'(gpio_out), '0);
      check_value("gpio_dir", word_t'(gpio_dir), '0);
      check_value("interrupt", word_t'(interrupt), '0);
      check_value("led_red", word_t'(led_red), '0);
      check_value("led_green", word_t'(led_green), '0);
      check_value("led_blue", word_t'(led_blue), '0);
      k = cycle_count - release_cycle - 1; // Edges after the release edge
      while (core_reset && k < 64)
      begin
         @(negedge clk);
         k = cycle_count - release_cycle - 1;
      end
      expect_true(k >= STRETCH - 1 && k <= STRETCH + 1,
         $sformatf("core_reset fell %0d cycles after release, expected %0d to %0d",
                   k, STRETCH - 1, STRETCH + 1));
   endtask

   task automatic test_ram();
      word_t      addr [8];
      word_t      model [8];
      word_t      data;
      word_t      rd;
      byte_mask_t mask;
      for (int i = 0; i < 8; i++)
      begin
         addr[i]  = word_t'((i * 37 + 3) % RAM_WORDS) << 2; // Spread over the RAM
         model[i] = $urandom();
         bus_write(addr[i], model[i], 4'hF);
      end
      for (int i = 0; i < 8; i++)
      begin
         data = $urandom();
         mask = byte_mask_t'($urandom_range(14, 1)); // Never the full word
         bus_write(addr[i], data, mask);
         model[i] = merge_bytes(model[i], data, mask);
      end
      bus_write(32'h2000_0000 | addr[0], ~model[0], 4'hF); // Unmapped region aliasing addr[0]
      for (int i = 0; i < 8; i++)
      begin
         bus_read(addr[i], rd);
         check_value($sformatf("mem_rdata at 0x%08h", addr[i]), rd, model[i]);
      end
      bus_read(32'h8000_0010, rd);
      check_value("mem_rdata unmapped", rd, '0);
   endtask

   task automatic gpio_write_check(input int bit_idx, input io_op_t op,
                                   input word_t data, input gpio_t expected);
      word_t rd;
      gpio_t pin;
      string name;
      bus_write(io_address(bit_idx, op), data, 4'hF);
      @(negedge clk);
      pin  = (bit_idx == IO_BIT_GPIO_OUT) ? gpio_out : gpio_dir;
      name = (bit_idx == IO_BIT_GPIO_OUT) ? "gpio_out" : "gpio_dir";
      check_value(name, word_t'(pin), word_t'(expected));
      bus_read(io_address(bit_idx, IO_OP_WRITE), rd);
      check_value({name, " readback"}, rd, word_t'(expected)); // Zero-extended
   endtask

   task automatic test_gpio_modifiers();
      gpio_t model;
      word_t data;
      int    bit_idx;
      for (int r = 0; r < 2; r++)
      begin
         bit_idx = (r == 0) ? IO_BIT_GPIO_OUT : IO_BIT_GPIO_DIR;
         data  = $urandom();
         model = data[7:0];            // Upper data bits dropped
         gpio_write_check(bit_idx, IO_OP_WRITE, data, model);
         data  = $urandom();
         model = model & ~data[7:0];   // Clear
         gpio_write_check(bit_idx, IO_OP_CLEAR, data, model);
         data  = $urandom();
         model = model | data[7:0];    // Set
         gpio_write_check(bit_idx, IO_OP_SET, data, model);
         data  = $urandom();
         model = model ^ data[7:0];    // Toggle
         gpio_write_check(bit_idx, IO_OP_TOGGLE, data, model);
      end
   endtask

   task automatic test_gpio_input();
      gpio_t value;
      word_t rd;
      for (int n = 0; n < 4; n++)
      begin
         value = gpio_t'($urandom());
         @(posedge clk);
         gpio_in <= value;
         repeat (2) @(posedge clk); // Through the input register
         bus_read(io_address(IO_BIT_GPIO_IN, IO_OP_WRITE), rd);
         check_value("gpio_in readback", rd, {24'h0, value});
      end
   endtask

   task automatic test_timer();
      int    period;
      int    k;
      word_t reload_val;
      word_t rd;
      bit    irq_expected;
      period     = $urandom_range(MAX_PERIOD, 6);
      k          = $urandom_range(MAX_K, 3);
      reload_val = 32'h0 - word_t'(period); // 2^32 - R is the period
      bus_write(io_address(IO_BIT_RELOAD, IO_OP_WRITE), reload_val, 4'hF);
      bus_read(io_address(IO_BIT_RELOAD, IO_OP_WRITE), rd);
      check_value("reload readback", rd, reload_val);
      bus_write(io_address(IO_BIT_TICKS, IO_OP_WRITE), 32'hFFFF_FFFF - word_t'(k), 4'hF);
      // j counts edges after the ticks write edge
      for (int j = 0; j <= k + 2 + 2 * period; j++)
      begin
         @(negedge clk);
         irq_expected = (j >= k + 1) && ((j - k - 1) % period == 0);
         check_value("interrupt", word_t'(interrupt), word_t'(irq_expected));
      end
   endtask

   task automatic test_leds();
      int         level_n;
      int         highs;
      int         expected;
      sdm_level_t level;
      word_t      rd;
      bus_write(io_address(IO_BIT_LEDS, IO_OP_WRITE), 32'h2, 4'hF); // Green only
      repeat (64)
      begin
         @(negedge clk);
         check_value("led_green", word_t'(led_green), 32'h1);
         check_value("led_red", word_t'(led_red), '0);   // Levels still zero
         check_value("led_blue", word_t'(led_blue), '0);
      end
      bus_write(io_address(IO_BIT_LEDS, IO_OP_CLEAR), 32'h2, 4'hF);
      level_n = $urandom_range(1023, 1);
      level   = sdm_level_t'(level_n * 64);
      bus_write(io_address(IO_BIT_SDM_RED, IO_OP_WRITE), word_t'(level), 4'hF);
      bus_read(io_address(IO_BIT_SDM_RED, IO_OP_WRITE), rd);
      check_value("red level readback", rd, word_t'(level));
      highs = 0;
      repeat (1024)
      begin
         @(negedge clk);
         if (led_red)
            highs++;
      end
      expected = int'(level) * 1024 / 65536;
      expect_true(highs >= expected - 1 && highs <= expected + 1,
         $sformatf("led_red was high %0d of 1024 cycles, expected %0d +-1", highs, expected));
   endtask

   initial
   begin
      reset_button = 1'b1;
      mem_address  = '0;
      mem_wdata    = '0;
      mem_wmask    = '0;
      mem_rstrb    = 1'b0;
      gpio_in      = '0;
      void'($urandom(375));
      test_reset();
      test_ram();
      test_gpio_modifiers();
      test_gpio_input();
      test_timer();
      test_leds();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // Hard limit on simulated time
   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
      $display("Testbench failed");
      $finish;
   end

endmodule

/* playground_props.sv */
// ##########################################################
// Bus slave protocol properties, bound into playground_top
// ##########################################################
`timescale 1ns/1ps

module playground_props (
   input logic                  clk,
   input logic                  reset_button,
   input logic                  core_reset,
   input logic                  interrupt,
   input playground_pkg::gpio_t gpio_out,
   input playground_pkg::gpio_t gpio_dir,
   input logic                  led_red,
   input logic                  led_green,
   input logic                  led_blue
);

   // Overflow pulse lasts one cycle
   interrupt_single_cycle: assert property (@(posedge clk) interrupt |=> !interrupt)
      else $error("interrupt stayed high for two consecutive cycles");

   // Button reaches the core reset directly
   reset_button_covered: assert property (@(posedge clk) reset_button |-> core_reset)
      else $error("core_reset low while reset_button is high");

   // Outputs dark one cycle after the button is seen
   outputs_low_in_reset: assert property (@(posedge clk)
      reset_button |=> (gpio_out == '0 && gpio_dir == '0 &&
                        !led_red && !led_green && !led_blue))
      else $error("GPIO or RGB outputs active after reset_button");

endmodule

bind playground_top playground_props props_i (
   .clk          (clk),
   .reset_button (reset_button),
   .core_reset   (core_reset),
   .interrupt    (interrupt),
   .gpio_out     (gpio_out),
   .gpio_dir     (gpio_dir),
   .led_red      (led_red),
   .led_green    (led_green),
   .led_blue     (led_blue)
);

/* playground_top.sv */
// ##########################################################
// Peripheral bus slave, no wait states and no busy signals
// Peripherals are held in reset while core_reset is high
// ##########################################################
`timescale 1ns/1ps

module playground_top #(
   parameter int RAM_WORDS          = 256, // Power of two
   parameter int RESET_STRETCH_BITS = 4
) (
   input  logic                       clk,
   input  logic                       reset_button,
   input  playground_pkg::word_t      mem_address,
   input  playground_pkg::word_t      mem_wdata,
   input  playground_pkg::byte_mask_t mem_wmask,
   input  logic                       mem_rstrb,
   output playground_pkg::word_t      mem_rdata,
   output logic                       core_reset,
   output logic                       interrupt,
   input  playground_pkg::gpio_t      gpio_in,
   output playground_pkg::gpio_t      gpio_out,
   output playground_pkg::gpio_t      gpio_dir,
   output logic                       led_red,
   output logic                       led_green,
   output logic                       led_blue
);

   import playground_pkg::*;

   localparam int RAM_ADDR_BITS = $clog2(RAM_WORDS);

   byte_mask_t ram_wmask;
   word_t      ram_rdata;
   word_t      io_rdata;
   logic       io_wstrb;
   logic       io_rstrb;
   word_t      ticks;
   word_t      reload;
   logic       ticks_wr;
   logic       reload_wr;
   led_bits_t  led_bits;
   sdm_level_t level_red;
   sdm_level_t level_green;
   sdm_level_t level_blue;

   reset_stretch #(
      .RESET_STRETCH_BITS(RESET_STRETCH_BITS)
   ) u_reset_stretch (
      .clk          (clk),
      .reset_button (reset_button),
      .core_reset   (core_reset)
   );

   bus_decode u_bus_decode (
      .mem_address (mem_address),
      .mem_wmask   (mem_wmask),
      .mem_rstrb   (mem_rstrb),
      .ram_rdata   (ram_rdata),
      .io_rdata    (io_rdata),
      .ram_wmask   (ram_wmask),
      .io_wstrb    (io_wstrb),
      .io_rstrb    (io_rstrb),
      .mem_rdata   (mem_rdata)
   );

   // Word address from byte address, upper bits alias within the region
   word_ram #(
      .RAM_WORDS(RAM_WORDS)
   ) u_word_ram (
      .clk       (clk),
      .ram_wmask (ram_wmask),
      .word_addr (mem_address[RAM_ADDR_BITS+1:2]),
      .wdata     (mem_wdata),
      .rdata     (ram_rdata)
   );

   io_regs u_io_regs (
      .clk         (clk),
      .reset       (core_reset),
      .io_wstrb    (io_wstrb),
      .io_rstrb    (io_rstrb),
      .mem_address (mem_address),
      .mem_wdata   (mem_wdata),
      .gpio_in     (gpio_in),
      .ticks       (ticks),
      .reload      (reload),
      .io_rdata    (io_rdata),
      .gpio_out    (gpio_out),
      .gpio_dir    (gpio_dir),
      .led_bits    (led_bits),
      .level_red   (level_red),
      .level_green (level_green),
      .level_blue  (level_blue),
      .ticks_wr    (ticks_wr),
      .reload_wr   (reload_wr)
   );

   interval_timer u_interval_timer (
      .clk       (clk),
      .reset     (core_reset),
      .ticks_wr  (ticks_wr),
      .reload_wr (reload_wr),
      .wdata     (mem_wdata), // Raw data, modifier bits ignored
      .ticks     (ticks),
      .reload    (reload),
      .interrupt (interrupt)
   );

   led_sdm u_led_sdm (
      .clk         (clk),
      .reset       (core_reset),
      .led_bits    (led_bits),
      .level_red   (level_red),
      .level_green (level_green),
      .level_blue  (level_blue),
      .led_red     (led_red),
      .led_green   (led_green),
      .led_blue    (led_blue)
   );

endmodule

/* led_sdm.sv */
// ##########################################################
// Three first-order sigma-delta channels, duty = level/65536
// Plain LED bits force their pin on
// ##########################################################
`timescale 1ns/1ps

module led_sdm (
   input  logic                       clk,
   input  logic                       reset,
   input  playground_pkg::led_bits_t  led_bits,
   input  playground_pkg::sdm_level_t level_red,
   input  playground_pkg::sdm_level_t level_green,
   input  playground_pkg::sdm_level_t level_blue,
   output logic                       led_red,
   output logic                       led_green,
   output logic                       led_blue
);

   import playground_pkg::*;

   sdm_level_t  level [3];     // Index 0 red, 1 green, 2 blue
   sdm_level_t  phase [3];     // Phase accumulators
   logic [16:0] phase_sum [3]; // Next phase with carry
   logic [2:0]  carry_q;       // Registered carries

   assign level[0] = level_red;
   assign level[1] = level_green;
   assign level[2] = level_blue;

   always_comb
   begin
      for (int i = 0; i < 3; i++)
         phase_sum[i] = {1'b0, phase[i]} + {1'b0, level[i]};
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < 3; i++)
            phase[i] <= '0;
         carry_q <= '0;
      end
      else
      begin
         for (int i = 0; i < 3; i++)
         begin
            phase[i]   <= phase_sum[i][15:0];
            carry_q[i] <= phase_sum[i][16]; // One pulse per 65536 of level
         end
      end
   end

   assign led_red   = led_bits[0] | carry_q[0];
   assign led_green = led_bits[1] | carry_q[1];
   assign led_blue  = led_bits[2] | carry_q[2];

endmodule

/* interval_timer.sv */
// ##########################################################
// 32-bit up counter, reloads after all ones
// Interrupt is a one-cycle pulse per overflow
// ##########################################################
`timescale 1ns/1ps

module interval_timer (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  ticks_wr,
   input  logic                  reload_wr,
   input  playground_pkg::word_t wdata,
   output playground_pkg::word_t ticks,
   output playground_pkg::word_t reload,
   output logic                  interrupt
);

   import playground_pkg::*;

   logic [32:0] ticks_sum;  // Count plus one, bit 32 is the overflow
   word_t       ticks_next; // Count or reload value

   assign ticks_sum  = {1'b0, ticks} + 33'd1;
   assign ticks_next = ticks_sum[32] ? reload : ticks_sum[31:0];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ticks     <= '0;
         reload    <= '0;
         interrupt <= 1'b0;
      end
      else
      begin
         ticks <= ticks_wr ? wdata : ticks_next; // Software write wins
         if (reload_wr)
            reload <= wdata;
         interrupt <= ticks_sum[32]; // High in the cycle ticks shows reload
      end
   end

endmodule

/* io_regs.sv */
// ##########################################################
// One-hot IO registers, word writes only, byte mask ignored
// Read value is captured on io_rstrb and held until the next
// ##########################################################
`timescale 1ns/1ps

module io_regs (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       io_wstrb,
   input  logic                       io_rstrb,
   input  playground_pkg::word_t      mem_address,
   input  playground_pkg::word_t      mem_wdata,
   input  playground_pkg::gpio_t      gpio_in,
   input  playground_pkg::word_t      ticks,
   input  playground_pkg::word_t      reload,
   output playground_pkg::word_t      io_rdata,
   output playground_pkg::gpio_t      gpio_out,
   output playground_pkg::gpio_t      gpio_dir,
   output playground_pkg::led_bits_t  led_bits,
   output playground_pkg::sdm_level_t level_red,
   output playground_pkg::sdm_level_t level_green,
   output playground_pkg::sdm_level_t level_blue,
   output logic                       ticks_wr,
   output logic                       reload_wr
);

   import playground_pkg::*;

   gpio_t  gpio_in_q; // Input pins, one register stage
   word_t  rd_value;  // Combined read value of the selected registers
   word_t  mod_value; // Write data after the modifier
   io_op_t op;        // Write, clear, set or toggle

   always_ff @(posedge clk)
   begin
      gpio_in_q <= gpio_in;
   end

   // OR of all selected registers
   always_comb
   begin
      rd_value = '0;
      if (mem_address[IO_BIT_GPIO_IN])   rd_value |= word_t'(gpio_in_q);
      if (mem_address[IO_BIT_GPIO_OUT])  rd_value |= word_t'(gpio_out);
      if (mem_address[IO_BIT_GPIO_DIR])  rd_value |= word_t'(gpio_dir);
      if (mem_address[IO_BIT_LEDS])      rd_value |= word_t'(led_bits);
      if (mem_address[IO_BIT_SDM_RED])   rd_value |= word_t'(level_red);
      if (mem_address[IO_BIT_SDM_GREEN]) rd_value |= word_t'(level_green);
      if (mem_address[IO_BIT_SDM_BLUE])  rd_value |= word_t'(level_blue);
      if (mem_address[IO_BIT_TICKS])     rd_value |= ticks;
      if (mem_address[IO_BIT_RELOAD])    rd_value |= reload;
   end

   assign op = mem_address[3:2];

   // Modifier works against the current read value
   always_comb
   begin
      case (op)
         IO_OP_CLEAR:  mod_value = rd_value & ~mem_wdata;
         IO_OP_SET:    mod_value = rd_value | mem_wdata;
         IO_OP_TOGGLE: mod_value = rd_value ^ mem_wdata;
         default:      mod_value = mem_wdata; // IO_OP_WRITE
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         gpio_out    <= '0;
         gpio_dir    <= '0;
         led_bits    <= '0; // All pins dark
         level_red   <= '0;
         level_green <= '0;
         level_blue  <= '0;
      end
      else if (io_wstrb)
      begin
         if (mem_address[IO_BIT_GPIO_OUT])  gpio_out    <= mod_value[7:0];
         if (mem_address[IO_BIT_GPIO_DIR])  gpio_dir    <= mod_value[7:0];
         if (mem_address[IO_BIT_LEDS])      led_bits    <= mod_value[2:0];
         if (mem_address[IO_BIT_SDM_RED])   level_red   <= mod_value[15:0];
         if (mem_address[IO_BIT_SDM_GREEN]) level_green <= mod_value[15:0];
         if (mem_address[IO_BIT_SDM_BLUE])  level_blue  <= mod_value[15:0];
      end
   end

   // Timer takes raw write data, no modifier
   assign ticks_wr  = io_wstrb & mem_address[IO_BIT_TICKS];
   assign reload_wr = io_wstrb & mem_address[IO_BIT_RELOAD];

   // Snapshot of the strobe cycle, master samples it one cycle later
   always_ff @(posedge clk)
   begin
      if (io_rstrb)
         io_rdata <= rd_value;
   end

endmodule

/* word_ram.sv */
// ##########################################################
// Synchronous word RAM with byte write mask, no reset
// RAM_WORDS must be a power of two, read is registered
// ##########################################################
`timescale 1ns/1ps

module word_ram #(
   parameter int RAM_WORDS = 256
) (
   input  logic                         clk,
   input  playground_pkg::byte_mask_t   ram_wmask,
   input  logic [$clog2(RAM_WORDS)-1:0] word_addr,
   input  playground_pkg::word_t        wdata,
   output playground_pkg::word_t        rdata
);

   import playground_pkg::*;

   word_t mem [RAM_WORDS]; // Contents undefined until written

   // Byte lanes
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < 4; b++)
      begin
         if (ram_wmask[b])
            mem[word_addr][8*b +: 8] <= wdata[8*b +: 8];
      end
   end

   // Read every cycle
   // Write in the same cycle returns the old word
   always_ff @(posedge clk)
   begin
      rdata <= mem[word_addr];
   end

endmodule

/* bus_decode.sv */
// ##########################################################
// Only RAM and IO regions are mapped, others read zero
// Read data follows the address held after the strobe
// ##########################################################
`timescale 1ns/1ps

module bus_decode (
   input  playground_pkg::word_t      mem_address,
   input  playground_pkg::byte_mask_t mem_wmask,
   input  logic                       mem_rstrb,
   input  playground_pkg::word_t      ram_rdata,
   input  playground_pkg::word_t      io_rdata,
   output playground_pkg::byte_mask_t ram_wmask,
   output logic                       io_wstrb,
   output logic                       io_rstrb,
   output playground_pkg::word_t      mem_rdata
);

   import playground_pkg::*;

   region_t region;    // Address bits 31..28
   logic    is_ram;    // RAM region selected
   logic    is_io;     // IO region selected
   logic    mem_wstrb; // Any byte written

   assign region    = mem_address[31:28];
   assign is_ram    = (region == REGION_RAM);
   assign is_io     = (region == REGION_IO);
   assign mem_wstrb = |mem_wmask;

   // RAM keeps the byte mask
   assign ram_wmask = mem_wmask & {4{is_ram}};

   // IO registers are written as whole words
   assign io_wstrb = mem_wstrb & is_io;
   assign io_rstrb = mem_rstrb & is_io;

   // Read data mux
   // Both sources are registered, so the address held by the master
   // in the sample cycle still selects the right one
   always_comb
   begin
      mem_rdata = '0;
      if (is_ram)
         mem_rdata |= ram_rdata;
      if (is_io)
         mem_rdata |= io_rdata; // Buffered value from the strobe cycle
   end

endmodule

/* reset_stretch.sv */
// ##########################################################
// Core reset follows reset_button and is held for
// 2^RESET_STRETCH_BITS cycles after its release
// ##########################################################
`timescale 1ns/1ps

module reset_stretch #(
   parameter int RESET_STRETCH_BITS = 4
) (
   input  logic clk,
   input  logic reset_button,
   output logic core_reset
);

   logic [RESET_STRETCH_BITS-1:0] stretch_cnt;  // Cycles since release
   logic                          stretch_done; // Counter saturated
   logic                          stretch_q;    // Registered part of core reset

   assign stretch_done = &stretch_cnt;

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         stretch_cnt <= '0;
         stretch_q   <= 1'b1;
      end
      else
      begin
         if (!stretch_done)
            stretch_cnt <= stretch_cnt + 1'b1; // Saturates at all ones
         stretch_q <= ~stretch_done; // Falls on the edge after saturation
      end
   end

   // Button reaches the core without waiting for an edge
   assign core_reset = reset_button | stretch_q;

endmodule

/* playground_pkg.sv */
// ##########################################################
// Bus, register and region types shared by the subsystem
// IO select bits must stay below bit 28, the region field
// ##########################################################

package playground_pkg;

   // Bus widths
   typedef logic [31:0] word_t;      // Address or data word
   typedef logic [3:0]  byte_mask_t; // Write byte mask, nonzero means write

   // Memory map, region lives in address bits 31..28
   typedef logic [3:0] region_t;

   localparam region_t REGION_RAM = 4'h0; // 0x0000_0000
   localparam region_t REGION_IO  = 4'h4; // 0x4000_0000

   // IO modifier from address bits 3..2
   typedef logic [1:0] io_op_t;

   localparam io_op_t IO_OP_WRITE  = 2'd0; // Plain write, +0
   localparam io_op_t IO_OP_CLEAR  = 2'd1; // Clear bits set in data, +4
   localparam io_op_t IO_OP_SET    = 2'd2; // Set bits, +8
   localparam io_op_t IO_OP_TOGGLE = 2'd3; // Flip bits, +12

   // Peripheral register types
   typedef logic [7:0]  gpio_t;      // GPIO port
   typedef logic [2:0]  led_bits_t;  // [0] red, [1] green, [2] blue
   typedef logic [15:0] sdm_level_t; // Brightness level or phase

   // One-hot IO register select bits
   // Several bits at once read back ORed and write all selected registers
   localparam int IO_BIT_GPIO_IN   = 4;  // R   GPIO input, registered once
   localparam int IO_BIT_GPIO_OUT  = 5;  // RW  GPIO output
   localparam int IO_BIT_GPIO_DIR  = 6;  // RW  GPIO direction
   localparam int IO_BIT_LEDS      = 8;  // RW  Plain LED bits
   localparam int IO_BIT_SDM_RED   = 9;  // RW  Red modulator level
   localparam int IO_BIT_SDM_GREEN = 10; // RW  Green modulator level
   localparam int IO_BIT_SDM_BLUE  = 11; // RW  Blue modulator level
   localparam int IO_BIT_TICKS     = 18; // RW  Timer count
   localparam int IO_BIT_RELOAD    = 19; // RW  Timer reload value

   // Bits 7, 12..17 and 20..27 are unused
   // A read of them alone returns zero

endpackage
